//--- source/issue_cfg.svh
`ifndef ISSUE_CFG_SVH
`define ISSUE_CFG_SVH

////////////////////////////////////////////////////////////
// sizes
////////////////////////////////////////////////////////////

`define ISSUE_DEPTH         8
`define ISSUE_PTR_BITS      3
`define QCOUNT_BITS         4   // holds 0 to ISSUE_DEPTH.
`define INST_WIDTH          32
`define ADDR_WIDTH          32
`define INST_ID_WIDTH       8
`define NUM_REGISTERS_LOG2  5
`define NUM_REG_MASKS       3
`define OP_CODE_BITS        6
`define MEM_OP_BITS         2
`define PIPE_BITS           2

////////////////////////////////////////////////////////////
// instruction fields and opcodes
////////////////////////////////////////////////////////////

`define OPCODE_MSB          31
`define OPCODE_LSB          26
`define REG_RS_MSB          25
`define REG_RS_LSB          21
`define REG_RT_MSB          20
`define REG_RT_LSB          16
`define REG_RD_MSB          15
`define REG_RD_LSB          11

`define OP_CODE_NOP         6'b000000
`define OP_CODE_CMP         6'b001010   // register alu group.
`define OP_CODE_TEST        6'b001011
`define OP_CODE_CMPI        6'b011010   // immediate alu group.
`define OP_CODE_TESTI       6'b011011
`define OP_CODE_LW          6'b100000
`define OP_CODE_SW          6'b100001
`define OP_CODE_JR          6'b111000   // sits in the jump group.

`define REG_MASK_RS0        3'b001
`define REG_MASK_RS1        3'b010
`define REG_MASK_RD         3'b100

`define MEM_OP_NONE         2'b00
`define MEM_OP_READ         2'b01

`define PIPE_ALU            2'd0
`define PIPE_BRANCH         2'd1
`define PIPE_MEMORY         2'd2

`endif

//--- source/issue_pkg.sv
`include "issue_cfg.svh"

package issue_pkg;

  // instruction payload.
  typedef logic [`INST_WIDTH-1:0]         inst_t;
  typedef logic [`ADDR_WIDTH-1:0]         addr_t;
  typedef logic [`INST_ID_WIDTH-1:0]      inst_id_t;

  // decode fields.
  typedef logic [`NUM_REGISTERS_LOG2-1:0] reg_idx_t;
  typedef logic [`OP_CODE_BITS-1:0]       opcode_t;
  typedef logic [`NUM_REG_MASKS-1:0]      reg_mask_t;
  typedef logic [`MEM_OP_BITS-1:0]        mem_op_t;
  typedef logic [`PIPE_BITS-1:0]          pipe_t;

  // queue bookkeeping.
  typedef logic [`QCOUNT_BITS-1:0]        qcount_t;
  typedef logic [`ISSUE_PTR_BITS-1:0]     qptr_t;

  // one bit per head slot.
  typedef logic [1:0]                     issue_mask_t;

endpackage

//--- source/issue_queue.sv
`include "issue_cfg.svh"

module issue_queue (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                flush,
  input  logic                push0,
  input  logic                push1,
  input  issue_pkg::inst_t    push_inst0,
  input  issue_pkg::inst_t    push_inst1,
  input  issue_pkg::addr_t    push_pc0,
  input  issue_pkg::addr_t    push_pc1,
  input  issue_pkg::inst_id_t push_id0,
  input  issue_pkg::inst_id_t push_id1,
  input  logic [1:0]          pop_count,
  output logic                head_valid0,
  output logic                head_valid1,
  output issue_pkg::inst_t    head_inst0,
  output issue_pkg::inst_t    head_inst1,
  output issue_pkg::addr_t    head_pc0,
  output issue_pkg::addr_t    head_pc1,
  output issue_pkg::inst_id_t head_id0,
  output issue_pkg::inst_id_t head_id1,
  output issue_pkg::qcount_t  free
);
  import issue_pkg::*;

  inst_t    mem_inst [`ISSUE_DEPTH];
  addr_t    mem_pc   [`ISSUE_DEPTH];
  inst_id_t mem_id   [`ISSUE_DEPTH];

  qptr_t    rd_ptr;
  qptr_t    wr_ptr;
  qptr_t    rd_ptr1;
  qptr_t    wr_ptr1;
  qcount_t  count;
  qcount_t  push_num;

  assign push_num = qcount_t'(push0) + qcount_t'(push1);
  assign wr_ptr1  = wr_ptr + qptr_t'(push0);  // push1 lands behind push0.
  assign rd_ptr1  = rd_ptr + qptr_t'(1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      rd_ptr <= rd_ptr + qptr_t'(pop_count);
      wr_ptr <= wr_ptr + qptr_t'(push_num);
      count  <= count + push_num - qcount_t'(pop_count);
    end
  end

  always_ff @(posedge clk) begin
    if (!flush) begin
      if (push0) begin
        mem_inst[wr_ptr] <= push_inst0;
        mem_pc[wr_ptr]   <= push_pc0;
        mem_id[wr_ptr]   <= push_id0;
      end
      if (push1) begin
        mem_inst[wr_ptr1] <= push_inst1;
        mem_pc[wr_ptr1]   <= push_pc1;
        mem_id[wr_ptr1]   <= push_id1;
      end
    end
  end

  // head window.
  assign head_valid0 = count != '0;
  assign head_valid1 = count > qcount_t'(1);
  assign head_inst0  = mem_inst[rd_ptr];
  assign head_inst1  = mem_inst[rd_ptr1];
  assign head_pc0    = mem_pc[rd_ptr];
  assign head_pc1    = mem_pc[rd_ptr1];
  assign head_id0    = mem_id[rd_ptr];
  assign head_id1    = mem_id[rd_ptr1];

  assign free = qcount_t'(`ISSUE_DEPTH) - count;

  a_push_fits: assert property (@(posedge clk) disable iff (!rst_n) push_num <= free)
    else $error("issue_queue: more pushes than free entries");
  a_pop_fits: assert property (@(posedge clk) disable iff (!rst_n)
    qcount_t'(pop_count) <= count)
    else $error("issue_queue: pop count beyond stored entries");
  a_pop_pair: assert property (@(posedge clk) disable iff (!rst_n)
    (pop_count > 2'd1) |-> head_valid1)
    else $error("issue_queue: double pop with one head entry");

endmodule

//--- source/reg_depends.sv
`include "issue_cfg.svh"

module reg_depends (
  input  issue_pkg::inst_t     instruction,
  output issue_pkg::reg_idx_t  reg_src0,
  output issue_pkg::reg_idx_t  reg_src1,
  output issue_pkg::reg_idx_t  reg_dest,
  output issue_pkg::reg_mask_t vld_mask
);
  import issue_pkg::*;

  opcode_t  opcode;
  reg_idx_t rs;
  reg_idx_t rt;
  reg_idx_t rd;

  assign opcode = instruction[`OPCODE_MSB:`OPCODE_LSB];
  assign rs     = instruction[`REG_RS_MSB:`REG_RS_LSB];
  assign rt     = instruction[`REG_RT_MSB:`REG_RT_LSB];
  assign rd     = instruction[`REG_RD_MSB:`REG_RD_LSB];

  always_comb begin
    reg_src0 = '0;
    reg_src1 = '0;
    reg_dest = '0;
    vld_mask = '0;
    casez (opcode)
      `OP_CODE_NOP: begin
      end
      `OP_CODE_JR: begin
        reg_src0 = rs;
        vld_mask = `REG_MASK_RS0;
      end
      6'b00????: begin  // register alu ops.
        reg_src0 = rs;
        reg_src1 = rt;
        reg_dest = rd;
        vld_mask = `REG_MASK_RS0 | `REG_MASK_RS1 | `REG_MASK_RD;
      end
      6'b01????: begin  // immediate ops write rt.
        reg_src0 = rs;
        reg_dest = rt;
        vld_mask = `REG_MASK_RS0 | `REG_MASK_RD;
      end
      6'b10????: begin
        if (opcode == `OP_CODE_LW) begin
          reg_src0 = rs;
          reg_dest = rt;
          vld_mask = `REG_MASK_RS0 | `REG_MASK_RD;
        end else if (opcode == `OP_CODE_SW) begin
          reg_src0 = rs;
          reg_src1 = rt;
          vld_mask = `REG_MASK_RS0 | `REG_MASK_RS1;
        end
      end
      default: begin  // jumps touch no registers.
      end
    endcase
  end

endmodule

//--- source/hazard_check.sv
`include "issue_cfg.svh"

module hazard_check (
  input  logic                   head_valid0,
  input  logic                   head_valid1,
  input  issue_pkg::inst_t       if_id_instruction1,
  input  issue_pkg::mem_op_t     if_id_mem_op1,
  input  issue_pkg::reg_idx_t    src0_a,
  input  issue_pkg::reg_idx_t    src1_a,
  input  issue_pkg::reg_idx_t    dest_a,
  input  issue_pkg::reg_idx_t    src0_b,
  input  issue_pkg::reg_idx_t    src1_b,
  input  issue_pkg::reg_idx_t    dest_b,
  input  issue_pkg::reg_mask_t   mask_a,
  input  issue_pkg::reg_mask_t   mask_b,
  output issue_pkg::issue_mask_t hazard_mask
);
  import issue_pkg::*;

  reg_idx_t if_id_rt;
  logic     load_read;
  logic     load_hit_a;
  logic     load_hit_b;
  logic     dest_a_vld;
  logic     pair_dep;

  assign if_id_rt  = if_id_instruction1[`REG_RT_MSB:`REG_RT_LSB];
  assign load_read = if_id_mem_op1 == `MEM_OP_READ;

  // load in decode against either head slot.
  assign load_hit_a = head_valid0 &&
    ((|(mask_a & `REG_MASK_RS0) && src0_a == if_id_rt) ||
     (|(mask_a & `REG_MASK_RS1) && src1_a == if_id_rt));
  assign load_hit_b = head_valid1 &&
    ((|(mask_b & `REG_MASK_RS0) && src0_b == if_id_rt) ||
     (|(mask_b & `REG_MASK_RS1) && src1_b == if_id_rt));

  assign dest_a_vld = |(mask_a & `REG_MASK_RD);

  // slot 1 reading slot 0's result.
  assign pair_dep = dest_a_vld &&
    ((|(mask_b & `REG_MASK_RS0) && src0_b == dest_a) ||
     (|(mask_b & `REG_MASK_RS1) && src1_b == dest_a));

  always_comb begin
    if (load_read && (load_hit_a || load_hit_b)) begin
      hazard_mask = 2'b00;
    end else begin
      hazard_mask = {head_valid1 && !pair_dep, head_valid0};
    end
  end

  a_mask_order: assert final (!(hazard_mask[1] && !hazard_mask[0]))
    else $error("hazard_check: slot 1 issues without slot 0");

endmodule

//--- source/steer.sv
`include "issue_cfg.svh"

module steer (
  input  issue_pkg::opcode_t     opcode0,
  input  issue_pkg::opcode_t     opcode1,
  input  logic                   head_valid1,
  input  issue_pkg::issue_mask_t hazard_mask,
  output issue_pkg::issue_mask_t issue_mask,
  output logic                   first
);
  import issue_pkg::*;

  pipe_t class0;
  pipe_t class1;
  logic  drop1;

  function automatic pipe_t pipe_class(input opcode_t op);
    pipe_t pc;
    casez (op)
      6'b11????: pc = `PIPE_BRANCH;
      6'b10????: pc = `PIPE_MEMORY;
      default: begin
        if (op == `OP_CODE_CMP || op == `OP_CODE_TEST ||
            op == `OP_CODE_CMPI || op == `OP_CODE_TESTI) begin
          pc = `PIPE_BRANCH;  // flag setters feed the branch pipe.
        end else begin
          pc = `PIPE_ALU;
        end
      end
    endcase
    return pc;
  endfunction

  assign class0 = pipe_class(opcode0);
  assign class1 = head_valid1 ? pipe_class(opcode1) : `PIPE_ALU;

  ////////////////////////////////////////////////////////////
  // lane 0 is branch, lane 1 is memory
  ////////////////////////////////////////////////////////////

  always_comb begin
    drop1 = 1'b0;
    first = 1'b0;
    case ({class0, class1})
      {`PIPE_BRANCH, `PIPE_BRANCH}: drop1 = 1'b1;  // one branch pipe.
      {`PIPE_MEMORY, `PIPE_MEMORY}: begin
        drop1 = 1'b1;
        first = 1'b1;
      end
      {`PIPE_MEMORY, `PIPE_BRANCH},
      {`PIPE_ALU, `PIPE_BRANCH},
      {`PIPE_MEMORY, `PIPE_ALU}: first = 1'b1;
      default: first = 1'b0;
    endcase
  end

  assign issue_mask = drop1 ? (hazard_mask & 2'b01) : hazard_mask;

endmodule

//--- source/issue.sv
`include "issue_cfg.svh"

module issue (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                flush,
  input  logic                push0,
  input  logic                push1,
  input  issue_pkg::inst_t    instruction0_in,
  input  issue_pkg::inst_t    instruction1_in,
  input  issue_pkg::addr_t    pc0_in,
  input  issue_pkg::addr_t    pc1_in,
  input  issue_pkg::inst_id_t id0_in,
  input  issue_pkg::inst_id_t id1_in,
  input  issue_pkg::inst_t    if_id_instruction1,
  input  issue_pkg::mem_op_t  if_id_mem_op1,
  output issue_pkg::qcount_t  free,
  output logic                stall,
  output logic                valid0_out,
  output logic                valid1_out,
  output issue_pkg::inst_t    instruction0_out,
  output issue_pkg::inst_t    instruction1_out,
  output issue_pkg::addr_t    pc0_out,
  output issue_pkg::addr_t    pc1_out,
  output issue_pkg::inst_id_t id0_out,
  output issue_pkg::inst_id_t id1_out
);
  import issue_pkg::*;

  logic        head_valid0;
  logic        head_valid1;
  inst_t       head_inst0;
  inst_t       head_inst1;
  addr_t       head_pc0;
  addr_t       head_pc1;
  inst_id_t    head_id0;
  inst_id_t    head_id1;
  reg_idx_t    src0_a;
  reg_idx_t    src1_a;
  reg_idx_t    dest_a;
  reg_idx_t    src0_b;
  reg_idx_t    src1_b;
  reg_idx_t    dest_b;
  reg_mask_t   mask_a;
  reg_mask_t   mask_b;
  issue_mask_t hazard_mask;
  issue_mask_t issue_mask;
  logic        first;
  logic [1:0]  pop_count;

  assign stall     = free == '0;
  assign pop_count = flush ? 2'd0 : 2'(issue_mask[0]) + 2'(issue_mask[1]);

  issue_queue q (
    .clk(clk), .rst_n(rst_n), .flush(flush),
    .push0(push0), .push1(push1),
    .push_inst0(instruction0_in), .push_inst1(instruction1_in),
    .push_pc0(pc0_in), .push_pc1(pc1_in),
    .push_id0(id0_in), .push_id1(id1_in),
    .pop_count(pop_count),
    .head_valid0(head_valid0), .head_valid1(head_valid1),
    .head_inst0(head_inst0), .head_inst1(head_inst1),
    .head_pc0(head_pc0), .head_pc1(head_pc1),
    .head_id0(head_id0), .head_id1(head_id1),
    .free(free)
  );

  reg_depends dep0 (
    .instruction(head_inst0), .reg_src0(src0_a), .reg_src1(src1_a),
    .reg_dest(dest_a), .vld_mask(mask_a)
  );

  reg_depends dep1 (
    .instruction(head_inst1), .reg_src0(src0_b), .reg_src1(src1_b),
    .reg_dest(dest_b), .vld_mask(mask_b)
  );

  hazard_check hc (
    .head_valid0(head_valid0), .head_valid1(head_valid1),
    .if_id_instruction1(if_id_instruction1), .if_id_mem_op1(if_id_mem_op1),
    .src0_a(src0_a), .src1_a(src1_a), .dest_a(dest_a),
    .src0_b(src0_b), .src1_b(src1_b), .dest_b(dest_b),
    .mask_a(mask_a), .mask_b(mask_b),
    .hazard_mask(hazard_mask)
  );

  steer st (
    .opcode0(head_inst0[`OPCODE_MSB:`OPCODE_LSB]),
    .opcode1(head_inst1[`OPCODE_MSB:`OPCODE_LSB]),
    .head_valid1(head_valid1), .hazard_mask(hazard_mask),
    .issue_mask(issue_mask), .first(first)
  );

  ////////////////////////////////////////////////////////////
  // lane placement
  ////////////////////////////////////////////////////////////

  always_comb begin
    valid0_out       = 1'b0;
    valid1_out       = 1'b0;
    instruction0_out = '0;
    instruction1_out = '0;
    pc0_out          = '0;
    pc1_out          = '0;
    id0_out          = '0;
    id1_out          = '0;
    if (!flush) begin
      if (issue_mask[0] && !first) begin
        valid0_out       = 1'b1;
        instruction0_out = head_inst0;
        pc0_out          = head_pc0;
        id0_out          = head_id0;
      end
      if (issue_mask[0] && first) begin  // swapped onto the memory lane.
        valid1_out       = 1'b1;
        instruction1_out = head_inst0;
        pc1_out          = head_pc0;
        id1_out          = head_id0;
      end
      if (issue_mask[1] && !first) begin
        valid1_out       = 1'b1;
        instruction1_out = head_inst1;
        pc1_out          = head_pc1;
        id1_out          = head_id1;
      end
      if (issue_mask[1] && first) begin
        valid0_out       = 1'b1;
        instruction0_out = head_inst1;
        pc0_out          = head_pc1;
        id0_out          = head_id1;
      end
    end
  end

endmodule

//--- testbench/tb_clock_gen.sv
module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // period 20.
  end

  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

//--- testbench/issue_tb.sv
`include "issue_cfg.svh"

module issue_tb;
  import issue_pkg::*;

  logic clk;
  logic rst_n;
  logic flush, push0, push1;
  inst_t instruction0_in, instruction1_in, if_id_instruction1;
  addr_t pc0_in, pc1_in;
  inst_id_t id0_in, id1_in;
  mem_op_t if_id_mem_op1;
  qcount_t free;
  logic stall, valid0_out, valid1_out;
  inst_t instruction0_out, instruction1_out;
  addr_t pc0_out, pc1_out;
  inst_id_t id0_out, id1_out;

  inst_t    mq_inst[$];  // model queue.
  addr_t    mq_pc[$];
  inst_id_t mq_id[$];

  int unsigned check_errors = 0;
  int unsigned timeout_errors = 0;
  string       test_name = "reset";
  logic [15:0] lfsr = 16'd31;
  inst_id_t    next_id = '0;

  tb_clock_gen clock_gen (.clk(clk), .rst_n(rst_n));

  issue issue_i (
    .clk(clk), .rst_n(rst_n), .flush(flush), .push0(push0), .push1(push1),
    .instruction0_in(instruction0_in), .instruction1_in(instruction1_in),
    .pc0_in(pc0_in), .pc1_in(pc1_in), .id0_in(id0_in), .id1_in(id1_in),
    .if_id_instruction1(if_id_instruction1), .if_id_mem_op1(if_id_mem_op1),
    .free(free), .stall(stall), .valid0_out(valid0_out), .valid1_out(valid1_out),
    .instruction0_out(instruction0_out), .instruction1_out(instruction1_out),
    .pc0_out(pc0_out), .pc1_out(pc1_out), .id0_out(id0_out), .id1_out(id1_out)
  );

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    logic        b;
    v = '0;
    for (int i = 0; i < n; i++) begin
      b = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) lfsr = lfsr ^ 16'hB400;  // galois taps.
      v = {v[14:0], b};
    end
    return v;
  endfunction

  function automatic inst_t make_inst(input opcode_t op, input int rs, rt, rd);
    inst_t w;
    w = '0;
    w[`OPCODE_MSB:`OPCODE_LSB] = op;
    w[`REG_RS_MSB:`REG_RS_LSB] = reg_idx_t'(rs);
    w[`REG_RT_MSB:`REG_RT_LSB] = reg_idx_t'(rt);
    w[`REG_RD_MSB:`REG_RD_LSB] = reg_idx_t'(rd);
    return w;
  endfunction

  function automatic inst_t rand_inst(input int base);
    opcode_t ops [8];
    opcode_t op;
    ops = '{6'b000001, 6'b010001, `OP_CODE_CMP, `OP_CODE_TESTI,
            `OP_CODE_LW, `OP_CODE_SW, `OP_CODE_JR, `OP_CODE_NOP};
    op = ops[rand_bits(3)];
    return make_inst(op, base + int'(rand_bits(2)), base + int'(rand_bits(2)),
                     base + int'(rand_bits(2)));
  endfunction

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  function automatic logic reads_reg(input inst_t w, input reg_idx_t r);
    opcode_t  op;
    reg_idx_t rs;
    reg_idx_t rt;
    op = w[`OPCODE_MSB:`OPCODE_LSB];
    rs = w[`REG_RS_MSB:`REG_RS_LSB];
    rt = w[`REG_RT_MSB:`REG_RT_LSB];
    if (op == `OP_CODE_NOP) return 1'b0;
    if (op == `OP_CODE_JR) return rs == r;
    if (op[5:4] == 2'b00 || op == `OP_CODE_SW) return rs == r || rt == r;
    if (op[5:4] == 2'b01 || op == `OP_CODE_LW) return rs == r;
    return 1'b0;
  endfunction

  function automatic logic writes_reg(input inst_t w, output reg_idx_t r);
    opcode_t op;
    op = w[`OPCODE_MSB:`OPCODE_LSB];
    r = '0;
    if (op == `OP_CODE_NOP) return 1'b0;
    if (op[5:4] == 2'b00) r = w[`REG_RD_MSB:`REG_RD_LSB];
    else if (op[5:4] == 2'b01 || op == `OP_CODE_LW) r = w[`REG_RT_MSB:`REG_RT_LSB];
    else return 1'b0;
    return 1'b1;
  endfunction

  function automatic pipe_t pipe_of(input inst_t w);
    opcode_t op;
    op = w[`OPCODE_MSB:`OPCODE_LSB];
    if (op[5:4] == 2'b11) return `PIPE_BRANCH;
    if (op == `OP_CODE_CMP || op == `OP_CODE_TEST ||
        op == `OP_CODE_CMPI || op == `OP_CODE_TESTI) return `PIPE_BRANCH;
    if (op[5:4] == 2'b10) return `PIPE_MEMORY;
    return `PIPE_ALU;
  endfunction

  // returns {swap, issue bit of slot 1, issue bit of slot 0}.
  function automatic logic [2:0] expect_issue(input inst_t i0, i1, input logic v0, v1,
                                              input logic fl, input inst_t dec,
                                              input mem_op_t dmem);
    logic [1:0] mask;
    pipe_t      c0;
    pipe_t      c1;
    logic       sw;
    reg_idx_t   d0;
    reg_idx_t   drt;
    if (fl || !v0) return 3'b000;
    drt = dec[`REG_RT_MSB:`REG_RT_LSB];
    if (dmem == `MEM_OP_READ && (reads_reg(i0, drt) || (v1 && reads_reg(i1, drt))))
      return 3'b000;  // load in decode blocks both.
    mask = {v1, 1'b1};
    if (v1 && writes_reg(i0, d0) && reads_reg(i1, d0)) mask[1] = 1'b0;
    c0 = pipe_of(i0);
    c1 = v1 ? pipe_of(i1) : `PIPE_ALU;
    sw = 1'b0;
    if (c0 == `PIPE_BRANCH && c1 == `PIPE_BRANCH) begin
      mask[1] = 1'b0;
    end else if (c0 == `PIPE_MEMORY && c1 == `PIPE_MEMORY) begin
      mask[1] = 1'b0;
      sw = 1'b1;
    end else if ((c0 == `PIPE_MEMORY && c1 == `PIPE_BRANCH) ||
                 (c0 == `PIPE_ALU && c1 == `PIPE_BRANCH) ||
                 (c0 == `PIPE_MEMORY && c1 == `PIPE_ALU)) begin
      sw = 1'b1;
    end
    return {sw, mask};
  endfunction

  task automatic check_val(input string label, input logic [63:0] exp, act);
    assert (exp === act) else begin
      check_errors++;
      $display("error %s %s: expected %0h, actual %0h", test_name, label, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // comparing process
  ////////////////////////////////////////////////////////////

  task automatic compare_cycle();
    logic [2:0] res;
    logic       v0, v1, ev0, ev1;
    inst_t      i0, i1, ei0, ei1;
    addr_t      ep0, ep1;
    inst_id_t   ed0, ed1;
    int         n;
    v0 = mq_inst.size() > 0;
    v1 = mq_inst.size() > 1;
    i0 = v0 ? mq_inst[0] : '0;
    i1 = v1 ? mq_inst[1] : '0;
    res = expect_issue(i0, i1, v0, v1, flush, if_id_instruction1, if_id_mem_op1);
    {ev0, ev1, ei0, ei1, ep0, ep1, ed0, ed1} = '0;
    for (int s = 0; s < 2; s++) begin
      if (res[s]) begin
        if ((s == 0) != res[2]) begin  // lands on lane 0.
          ev0 = 1'b1;
          ei0 = mq_inst[s];
          ep0 = mq_pc[s];
          ed0 = mq_id[s];
        end else begin
          ev1 = 1'b1;
          ei1 = mq_inst[s];
          ep1 = mq_pc[s];
          ed1 = mq_id[s];
        end
      end
    end
    check_val("valid0", ev0, valid0_out);
    check_val("valid1", ev1, valid1_out);
    check_val("inst0", ei0, instruction0_out);
    check_val("inst1", ei1, instruction1_out);
    check_val("pc0", ep0, pc0_out);
    check_val("pc1", ep1, pc1_out);
    check_val("id0", ed0, id0_out);
    check_val("id1", ed1, id1_out);
    check_val("free", `ISSUE_DEPTH - mq_inst.size(), free);
    check_val("stall", mq_inst.size() == `ISSUE_DEPTH, stall);
    // model state after the coming edge.
    if (flush) begin
      mq_inst.delete();
      mq_pc.delete();
      mq_id.delete();
    end else begin
      n = int'(res[0]) + int'(res[1]);
      repeat (n) begin
        void'(mq_inst.pop_front());
        void'(mq_pc.pop_front());
        void'(mq_id.pop_front());
      end
      if (push0) begin
        mq_inst.push_back(instruction0_in);
        mq_pc.push_back(pc0_in);
        mq_id.push_back(id0_in);
      end
      if (push1) begin
        mq_inst.push_back(instruction1_in);
        mq_pc.push_back(pc1_in);
        mq_id.push_back(id1_in);
      end
    end
  endtask

  always @(negedge clk) begin
    if (rst_n) compare_cycle();
  end

  ////////////////////////////////////////////////////////////
  // waits, each with its own timeout
  ////////////////////////////////////////////////////////////

  task automatic wait_free(input int n, input logic at_least);
    int t;
    t = 0;
    @(negedge clk);
    while ((at_least ? int'(free) < n : int'(free) != n) && t < 100) begin
      @(negedge clk);
      t++;
    end
    if (t >= 100) begin
      timeout_errors++;
      $display("%s: timed out waiting for the free count to reach %0d", test_name, n);
    end
  endtask

  task automatic wait_issue();
    int t;
    t = 0;
    @(negedge clk);
    while (!(valid0_out || valid1_out) && t < 50) begin
      @(negedge clk);
      t++;
    end
    if (t >= 50) begin
      timeout_errors++;
      $display("%s: timed out waiting for an instruction to issue", test_name);
    end
  endtask

  task automatic push_entries(input inst_t a, input inst_t b, input int n);
    wait_free(n, 1'b1);
    @(posedge clk);
    push0 <= 1'b1;
    push1 <= n == 2;
    instruction0_in <= a;
    instruction1_in <= b;
    id0_in <= next_id;
    id1_in <= next_id + 8'd1;
    pc0_in <= 32'h1000 + 4 * next_id;
    pc1_in <= 32'h1004 + 4 * next_id;
    next_id = next_id + inst_id_t'(n);
    @(posedge clk);
    push0 <= 1'b0;
    push1 <= 1'b0;
  endtask

  task automatic set_decode(input int rt, input mem_op_t mop);
    @(posedge clk);
    if_id_instruction1 <= make_inst(`OP_CODE_LW, 1, rt, 0);
    if_id_mem_op1 <= mop;
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    inst_id_t older;
    int       t;
    {flush, push0, push1} <= '0;
    {instruction0_in, instruction1_in, pc0_in, pc1_in} <= '0;
    {id0_in, id1_in} <= '0;
    if_id_instruction1 <= '0;
    if_id_mem_op1 <= `MEM_OP_NONE;
    t = 0;
    while (rst_n !== 1'b1 && t < 20) begin
      @(negedge clk);
      t++;
    end
    if (rst_n !== 1'b1) begin
      timeout_errors++;
      $display("%s: timed out waiting for reset to be released", test_name);
    end
    @(negedge clk);
    check_val("free", 8, free);
    check_val("stall", 0, stall);
    check_val("lane_valids", 0, {valid0_out, valid1_out});
    check_val("lane_insts", 0, {instruction0_out, instruction1_out});
    check_val("lane_pcs", 0, {pc0_out, pc1_out});
    check_val("lane_ids", 0, {id0_out, id1_out});

    test_name = "steering";
    repeat (16) begin
      push_entries(rand_inst(1), rand_inst(9), 2);  // disjoint registers.
      wait_free(8, 1'b0);
    end
    test_name = "random";
    repeat (24) push_entries(rand_inst(1), rand_inst(1), 2);
    wait_free(8, 1'b0);

    test_name = "intra_pair";
    older = next_id;
    push_entries(make_inst(6'b000001, 1, 2, 3), make_inst(`OP_CODE_CMP, 3, 4, 0), 2);
    wait_issue();
    check_val("single_lane", 1, valid0_out ^ valid1_out);
    check_val("older_id", older, valid0_out ? id0_out : id1_out);
    wait_issue();
    check_val("younger_id", older + 8'd1, valid0_out ? id0_out : id1_out);

    test_name = "load_use";
    set_decode(2, `MEM_OP_READ);
    older = next_id;
    push_entries(make_inst(`OP_CODE_SW, 2, 5, 0), '0, 1);
    repeat (4) begin
      @(negedge clk);
      check_val("blocked", 0, {valid0_out, valid1_out});
    end
    set_decode(2, `MEM_OP_NONE);
    wait_issue();
    check_val("released_id", older, valid0_out ? id0_out : id1_out);

    test_name = "full_queue";
    set_decode(2, `MEM_OP_READ);
    repeat (4) push_entries(make_inst(6'b010001, 2, 3, 0), make_inst(6'b010001, 2, 4, 0), 2);
    wait_free(0, 1'b0);
    check_val("stall", 1, stall);
    set_decode(2, `MEM_OP_NONE);
    wait_free(8, 1'b0);

    test_name = "flush";
    set_decode(2, `MEM_OP_READ);
    repeat (2) push_entries(make_inst(6'b000001, 2, 3, 4), make_inst(`OP_CODE_JR, 2, 0, 0), 2);
    @(posedge clk);
    flush <= 1'b1;
    if_id_mem_op1 <= `MEM_OP_NONE;  // head pair would issue but for flush.
    @(negedge clk);
    check_val("flush_valids", 0, {valid0_out, valid1_out});
    check_val("flush_insts", 0, {instruction0_out, instruction1_out});
    @(posedge clk);
    flush <= 1'b0;
    repeat (3) begin
      @(negedge clk);
      check_val("free", 8, free);
      check_val("idle", 0, {valid0_out, valid1_out});
    end

    repeat (2) @(negedge clk);
    $display("check errors: %0d, timeouts: %0d", check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- issue.f
+incdir+source
source/issue_pkg.sv
source/issue_queue.sv
source/reg_depends.sv
source/hazard_check.sv
source/steer.sv
source/issue.sv
testbench/tb_clock_gen.sv
testbench/issue_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the issue stage testbench with Verilator, runs it and scans the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f issue.f \
  --top-module issue_tb \
  -o issue_sim

./obj_dir/issue_sim | tee sim.log

if grep -q "Errors found" sim.log; then
  echo "simulation reported failures"
  exit 1
fi
echo "simulation passed"
